/* hdl/rr_defines.svh */
`ifndef RR_DEFINES_SVH
`define RR_DEFINES_SVH

// The bitmap of a unit has one bit per logging channel
`define RR_CHANNEL_CNT 4

// Data widths of the individual channels
`define RR_CH0_W 8
`define RR_CH1_W 16
`define RR_CH2_W 24
`define RR_CH3_W 32

// Memory word and word address
`define RR_WORD_W 64
`define RR_ADDR_W 32

// Longest unit is the bitmap plus every channel
`define RR_UNIT_W 84

// A length field holds 0 up to RR_UNIT_W
`define RR_LEN_W 7

`endif

/* hdl/rr_pkg.sv */
`default_nettype none

`include "rr_defines.svh"

package rr_pkg;

  typedef logic [`RR_UNIT_W-1:0]      unit_t;
  typedef logic [`RR_LEN_W-1:0]       unit_len_t;
  typedef logic [`RR_WORD_W-1:0]      word_t;
  typedef logic [`RR_ADDR_W-1:0]      word_addr_t;
  typedef logic [31:0]                bit_cnt_t;
  typedef logic [`RR_CHANNEL_CNT-1:0] bitmap_t;

  // Bit 2 replay done, bit 1 record full or finished, bit 0 reserved
  typedef logic [2:0] irq_reason_t;

  // The bit buffer of packer and unpacker holds one word plus one full unit
  typedef logic [`RR_WORD_W+`RR_UNIT_W-1:0] acc_t;
  typedef logic [7:0]                       acc_cnt_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_RUN,
    WR_FULL,
    WR_DONE
  } writer_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_DRAIN
  } reader_state_t;

  // Unit length is the bitmap itself plus the width of every valid channel
  function automatic unit_len_t unit_len(input bitmap_t bitmap);
    unit_len_t len;
    len = unit_len_t'(`RR_CHANNEL_CNT);
    if (bitmap[0]) len = len + unit_len_t'(`RR_CH0_W);
    if (bitmap[1]) len = len + unit_len_t'(`RR_CH1_W);
    if (bitmap[2]) len = len + unit_len_t'(`RR_CH2_W);
    if (bitmap[3]) len = len + unit_len_t'(`RR_CH3_W);
    return len;
  endfunction

endpackage

`default_nettype wire

/* hdl/rr_stream_if.sv */
`default_nettype none

`include "rr_defines.svh"

// A transfer on the valid/ready stream happens when both are high
interface rr_stream_if import rr_pkg::*; #(
  parameter int DATA_W = `RR_WORD_W
) ();

  logic              valid;
  logic              ready;
  logic [DATA_W-1:0] data;
  // Number of meaningful bits in data, counted from the LSB
  unit_len_t         len;

  modport p (output valid, output data, output len, input ready);

  modport c (input valid, input data, input len, output ready);

endinterface

`default_nettype wire

/* hdl/rr_trace_packer.sv */
`default_nettype none

`include "rr_defines.svh"

module rr_trace_packer import rr_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  rr_stream_if.c unit_in,
  rr_stream_if.p word_wr,
  input  logic   finish
);

  localparam int WORD_W = `RR_WORD_W;
  localparam int ACC_W = $bits(acc_t);

  acc_t     acc;
  acc_cnt_t fill;
  logic     flush_pend;
  logic     full_word;
  logic     take_unit;
  logic     send_word;
  unit_t    unit_mask;

  // Units are taken only while less than a word is pending
  assign full_word = fill >= acc_cnt_t'(WORD_W);
  assign unit_in.ready = !full_word && !flush_pend;
  assign take_unit = unit_in.valid && unit_in.ready;

  // Clears any bits above len so the accumulator stays zero padded
  assign unit_mask = (unit_t'(1) << unit_in.len) - unit_t'(1);

  // Full words go first, the remainder leaves as one short word on a flush
  assign word_wr.valid = full_word || flush_pend;
  assign word_wr.data = acc[WORD_W-1:0];
  assign word_wr.len = full_word ? unit_len_t'(WORD_W) : unit_len_t'(fill);
  assign send_word = word_wr.valid && word_wr.ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc <= '0;
      fill <= '0;
      flush_pend <= 1'b0;
    end else begin
      if (finish) begin
        flush_pend <= 1'b1;
      end
      if (take_unit) begin
        // New unit lands right above the bits already held
        acc <= acc | (acc_t'(unit_in.data & unit_mask) << fill);
        fill <= fill + acc_cnt_t'(unit_in.len);
      end else if (send_word) begin
        if (full_word) begin
          acc <= acc >> WORD_W;
          fill <= fill - acc_cnt_t'(WORD_W);
        end else begin
          acc <= '0;
          fill <= '0;
          flush_pend <= 1'b0;
        end
      end
    end
  end

  // A unit is only taken below one word of fill, so a full unit always fits
  a_fill_in_range: assert property (
    @(posedge clk) disable iff (!rstn)
    fill < acc_cnt_t'(ACC_W)
  );

endmodule

`default_nettype wire

/* hdl/rr_trace_writer.sv */
`default_nettype none

`include "rr_defines.svh"

module rr_trace_writer import rr_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  rr_stream_if.c     word_wr,
  input  word_addr_t buf_addr,
  input  word_addr_t buf_size,
  input  logic       buf_update,
  output logic       mem_wr_valid,
  output word_addr_t mem_wr_addr,
  output word_t      mem_wr_data,
  input  logic       mem_wr_ready,
  output bit_cnt_t   record_bits,
  output logic       wr_event
);

  localparam int WORD_W = `RR_WORD_W;

  writer_state_t state;
  word_addr_t    base;
  word_addr_t    size;
  word_addr_t    count;
  logic          last_word;
  logic          word_done;

  // Anything shorter than a full word is the flush word closing the record
  assign last_word = word_wr.len != unit_len_t'(WORD_W);

  // An empty flush word finishes the record without touching memory
  assign mem_wr_valid = (state == WR_RUN) && word_wr.valid && (word_wr.len != '0);
  assign mem_wr_addr = base + count;
  assign mem_wr_data = word_wr.data;
  assign word_wr.ready = (state == WR_RUN) && (mem_wr_ready || (word_wr.len == '0));
  assign word_done = word_wr.valid && word_wr.ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= WR_IDLE;
      count <= '0;
      record_bits <= '0;
      wr_event <= 1'b0;
    end else begin
      wr_event <= 1'b0;
      if (buf_update) begin
        count <= '0;
        record_bits <= '0;
        state <= (buf_size == '0) ? WR_FULL : WR_RUN;
      end else if (word_done) begin
        record_bits <= record_bits + bit_cnt_t'(word_wr.len);
        if (word_wr.len != '0) begin
          count <= count + word_addr_t'(1);
        end
        if (last_word) begin
          state <= WR_DONE;
          wr_event <= 1'b1;
        end else if (count + word_addr_t'(1) == size) begin
          // Stays full until software hands over a new buffer
          state <= WR_FULL;
          wr_event <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_update) begin
      base <= buf_addr;
      size <= buf_size;
    end
  end

  a_wr_in_buffer: assert property (
    @(posedge clk) disable iff (!rstn)
    mem_wr_valid |-> ((mem_wr_addr - base) < size)
  );

endmodule

`default_nettype wire

/* hdl/rr_trace_reader.sv */
`default_nettype none

`include "rr_defines.svh"

module rr_trace_reader import rr_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  word_addr_t buf_addr,
  input  logic       buf_update,
  input  bit_cnt_t   replay_bits,
  output logic       mem_rd_valid,
  output word_addr_t mem_rd_addr,
  input  logic       mem_rd_ready,
  input  logic       mem_rd_resp_valid,
  input  word_t      mem_rd_resp_data,
  rr_stream_if.p     word_rd
);

  localparam int WORD_W = `RR_WORD_W;
  localparam int LSB_W = $clog2(WORD_W);

  reader_state_t state;
  word_addr_t    req_addr;
  bit_cnt_t      req_left;
  bit_cnt_t      send_left;
  bit_cnt_t      n_words;
  unit_len_t     last_len;
  logic [1:0]    in_flight;
  logic [1:0]    fifo_cnt;
  word_t         fifo [2];
  logic          wr_ptr;
  logic          rd_ptr;
  logic          issue;
  logic          pop;

  // Words needed to cover replay_bits, rounded up
  assign n_words = (replay_bits >> LSB_W) + bit_cnt_t'(|replay_bits[LSB_W-1:0]);

  // Requests in flight plus words buffered never exceed the two FIFO slots
  assign mem_rd_valid = (state == RD_FETCH) && (in_flight != 2'd2);
  assign mem_rd_addr = req_addr;
  assign issue = mem_rd_valid && mem_rd_ready;

  assign word_rd.valid = fifo_cnt != 2'd0;
  assign word_rd.data = fifo[rd_ptr];
  assign word_rd.len = (send_left == bit_cnt_t'(1)) ? last_len : unit_len_t'(WORD_W);
  assign pop = word_rd.valid && word_rd.ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= RD_IDLE;
      req_left <= '0;
      send_left <= '0;
      in_flight <= '0;
      fifo_cnt <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      in_flight <= in_flight + {1'b0, issue} - {1'b0, pop};
      fifo_cnt <= fifo_cnt + {1'b0, mem_rd_resp_valid} - {1'b0, pop};
      if (mem_rd_resp_valid) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
        send_left <= send_left - bit_cnt_t'(1);
      end
      case (state)
        RD_IDLE: begin
          if (buf_update && (n_words != '0)) begin
            req_left <= n_words;
            send_left <= n_words;
            state <= RD_FETCH;
          end
        end
        RD_FETCH: begin
          if (issue) begin
            req_left <= req_left - bit_cnt_t'(1);
            if (req_left == bit_cnt_t'(1)) begin
              state <= RD_DRAIN;
            end
          end
        end
        default: begin
          if (pop && (send_left == bit_cnt_t'(1))) begin
            state <= RD_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (buf_update && (state == RD_IDLE)) begin
      req_addr <= buf_addr;
      // A zero remainder means the last word is full
      if (replay_bits[LSB_W-1:0] == '0) begin
        last_len <= unit_len_t'(WORD_W);
      end else begin
        last_len <= unit_len_t'(replay_bits[LSB_W-1:0]);
      end
    end else if (issue) begin
      req_addr <= req_addr + word_addr_t'(1);
    end
    if (mem_rd_resp_valid) begin
      fifo[wr_ptr] <= mem_rd_resp_data;
    end
  end

  a_fifo_no_overflow: assert property (
    @(posedge clk) disable iff (!rstn)
    mem_rd_resp_valid |-> ((fifo_cnt != 2'd2) || pop)
  );

endmodule

`default_nettype wire

/* hdl/rr_trace_unpacker.sv */
`default_nettype none

`include "rr_defines.svh"

module rr_trace_unpacker import rr_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  rr_stream_if.c   word_rd,
  rr_stream_if.p   unit_out,
  input  bit_cnt_t replay_bits,
  input  logic     start,
  output logic     rd_event
);

  localparam int UNIT_W = `RR_UNIT_W;

  acc_t      bbuf;
  acc_t      buf_next;
  acc_cnt_t  bcnt;
  acc_cnt_t  cnt_next;
  bit_cnt_t  remain;
  logic      active;
  unit_len_t cur_len;
  unit_t     unit_mask;
  word_t     word_mask;
  logic      push;
  logic      pop;
  logic      last_unit;

  // The bitmap of the next unit always sits in the low bits of the buffer
  assign cur_len = unit_len(bitmap_t'(bbuf[`RR_CHANNEL_CNT-1:0]));
  assign unit_mask = (unit_t'(1) << cur_len) - unit_t'(1);
  assign word_mask = (word_t'(1) << word_rd.len) - word_t'(1);

  // Unused bits above bcnt are zero, so a partial bitmap cannot fake a unit
  assign unit_out.valid = active && (bcnt >= acc_cnt_t'(cur_len));
  assign unit_out.data = bbuf[UNIT_W-1:0] & unit_mask;
  assign unit_out.len = cur_len;
  assign pop = unit_out.valid && unit_out.ready;

  // Room for one more word as long as no more than a full unit is held
  assign word_rd.ready = active && (bcnt <= acc_cnt_t'(UNIT_W));
  assign push = word_rd.valid && word_rd.ready;

  assign last_unit = remain <= bit_cnt_t'(cur_len);

  always_comb begin
    buf_next = bbuf;
    cnt_next = bcnt;
    if (pop) begin
      buf_next = bbuf >> cur_len;
      cnt_next = bcnt - acc_cnt_t'(cur_len);
    end
    if (push) begin
      buf_next = buf_next | (acc_t'(word_rd.data & word_mask) << cnt_next);
      cnt_next = cnt_next + acc_cnt_t'(word_rd.len);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      active <= 1'b0;
      bbuf <= '0;
      bcnt <= '0;
      remain <= '0;
      rd_event <= 1'b0;
    end else begin
      rd_event <= 1'b0;
      if (start) begin
        remain <= replay_bits;
        active <= replay_bits != '0;
        rd_event <= replay_bits == '0;
        bbuf <= '0;
        bcnt <= '0;
      end else if (pop && last_unit) begin
        // Whatever is left of the word is padding
        remain <= '0;
        active <= 1'b0;
        bbuf <= '0;
        bcnt <= '0;
        rd_event <= 1'b1;
      end else begin
        if (pop) begin
          remain <= remain - bit_cnt_t'(cur_len);
        end
        bbuf <= buf_next;
        bcnt <= cnt_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rr_irq_ctrl.sv */
`default_nettype none

module rr_irq_ctrl import rr_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        wr_event,
  input  logic        rd_event,
  output logic        irq_req,
  output irq_reason_t irq_reason,
  input  logic        irq_ack
);

  logic        any_event;
  irq_reason_t new_reason;

  // Both event inputs are single-cycle pulses
  assign any_event = wr_event | rd_event;
  assign new_reason = {rd_event, wr_event, 1'b0};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      irq_req <= 1'b0;
      irq_reason <= '0;
    end else if (irq_ack) begin
      // An event in the ack cycle opens the next request right away
      irq_req <= any_event;
      irq_reason <= new_reason;
    end else if (any_event) begin
      irq_req <= 1'b1;
      irq_reason <= irq_reason | new_reason;
    end
  end

  a_ack_while_pending: assert property (
    @(posedge clk) disable iff (!rstn)
    irq_ack |-> irq_req
  );

endmodule

`default_nettype wire

/* hdl/rr_storage_backend.sv */
`default_nettype none

`include "rr_defines.svh"

module rr_storage_backend import rr_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        in_valid,
  output logic        in_ready,
  input  unit_t       in_data,
  input  unit_len_t   in_len,
  output logic        out_valid,
  input  logic        out_ready,
  output unit_t       out_data,
  output unit_len_t   out_len,
  input  word_addr_t  buf_addr,
  input  word_addr_t  buf_size,
  input  logic        write_buf_update,
  input  logic        read_buf_update,
  input  logic        record_finish,
  input  bit_cnt_t    replay_bits,
  output bit_cnt_t    record_bits,
  output logic        mem_wr_valid,
  input  logic        mem_wr_ready,
  output word_addr_t  mem_wr_addr,
  output word_t       mem_wr_data,
  output logic        mem_rd_valid,
  input  logic        mem_rd_ready,
  output word_addr_t  mem_rd_addr,
  input  logic        mem_rd_resp_valid,
  input  word_t       mem_rd_resp_data,
  output logic        irq_req,
  output irq_reason_t irq_reason,
  input  logic        irq_ack
);

  logic rstn_q;
  logic wr_event;
  logic rd_event;

  rr_stream_if #(.DATA_W(`RR_UNIT_W)) unit_in ();
  rr_stream_if #(.DATA_W(`RR_WORD_W)) word_wr ();
  rr_stream_if #(.DATA_W(`RR_WORD_W)) word_rd ();
  rr_stream_if #(.DATA_W(`RR_UNIT_W)) unit_out ();

  // Reset passes one register stage, so every block sees it a cycle late
  always_ff @(posedge clk) begin
    rstn_q <= rstn;
  end

  assign unit_in.valid = in_valid;
  assign unit_in.data = in_data;
  assign unit_in.len = in_len;
  assign in_ready = unit_in.ready;

  assign out_valid = unit_out.valid;
  assign out_data = unit_out.data;
  assign out_len = unit_out.len;
  assign unit_out.ready = out_ready;

  rr_trace_packer i_packer (
    .clk     (clk),
    .rstn    (rstn_q),
    .unit_in (unit_in),
    .word_wr (word_wr),
    .finish  (record_finish)
  );

  rr_trace_writer i_writer (
    .clk          (clk),
    .rstn         (rstn_q),
    .word_wr      (word_wr),
    .buf_addr     (buf_addr),
    .buf_size     (buf_size),
    .buf_update   (write_buf_update),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_ready (mem_wr_ready),
    .record_bits  (record_bits),
    .wr_event     (wr_event)
  );

  rr_trace_reader i_reader (
    .clk               (clk),
    .rstn              (rstn_q),
    .buf_addr          (buf_addr),
    .buf_update        (read_buf_update),
    .replay_bits       (replay_bits),
    .mem_rd_valid      (mem_rd_valid),
    .mem_rd_addr       (mem_rd_addr),
    .mem_rd_ready      (mem_rd_ready),
    .mem_rd_resp_valid (mem_rd_resp_valid),
    .mem_rd_resp_data  (mem_rd_resp_data),
    .word_rd           (word_rd)
  );

  rr_trace_unpacker i_unpacker (
    .clk         (clk),
    .rstn        (rstn_q),
    .word_rd     (word_rd),
    .unit_out    (unit_out),
    .replay_bits (replay_bits),
    .start       (read_buf_update),
    .rd_event    (rd_event)
  );

  rr_irq_ctrl i_irq_ctrl (
    .clk        (clk),
    .rstn       (rstn_q),
    .wr_event   (wr_event),
    .rd_event   (rd_event),
    .irq_req    (irq_req),
    .irq_reason (irq_reason),
    .irq_ack    (irq_ack)
  );

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD = 20,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset is released just after a rising edge, like every other input
  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rstn = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
`default_nettype none

module tb_checker import rr_pkg::*; (
  input logic      clk,
  input logic      in_valid,
  input logic      in_ready,
  input unit_t     in_data,
  input unit_len_t in_len,
  input logic      out_valid,
  input logic      out_ready,
  input unit_t     out_data,
  input unit_len_t out_len
);

  int        err_cnt = 0;
  int        pass_cnt = 0;
  int        fail_cnt = 0;
  int        test_base = 0;
  int        match_cnt = 0;
  int        exp_left = 0;
  unit_t     rec_data[$];
  unit_len_t rec_len[$];
  unit_t     exp_data[$];
  unit_len_t exp_len[$];

  // Handshakes are sampled mid-cycle, they complete at the next rising edge
  always @(negedge clk) begin
    if (in_valid && in_ready) begin
      rec_data.push_back(in_data);
      rec_len.push_back(in_len);
    end
    if (out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        $display("Replay produced a unit at time %0t that was never recorded", $time);
        err_cnt++;
      end else begin
        check_value("out_data", 128'(out_data), 128'(exp_data[0]));
        check_value("out_len", 128'(out_len), 128'(exp_len[0]));
        void'(exp_data.pop_front());
        void'(exp_len.pop_front());
        match_cnt++;
      end
    end
    exp_left = exp_data.size();
  end

  task automatic start_record();
    rec_data.delete();
    rec_len.delete();
  endtask

  // The replay must return the recorded units again in the same order
  task automatic start_replay();
    exp_data = rec_data;
    exp_len = rec_len;
    exp_left = exp_data.size();
    match_cnt = 0;
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("Failure at time %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_base) begin
      $display("Test %s: PASS", name);
      pass_cnt++;
    end else begin
      $display("Test %s: FAIL (%0d errors)", name, err_cnt - test_base);
      fail_cnt++;
    end
    test_base = err_cnt;
  endtask

  task automatic summary();
    $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
  endtask

endmodule

`default_nettype wire

/* tb/tb_storage_backend.sv */
`default_nettype none

`include "rr_defines.svh"

module tb_storage_backend import rr_pkg::*; ();

  localparam int N_UNITS = 20;
  localparam int TMO = 2000;

  logic clk, rstn;
  logic in_valid, in_ready, out_valid, out_ready;
  unit_t in_data, out_data;
  unit_len_t in_len, out_len;
  word_addr_t buf_addr, buf_size, mem_wr_addr, mem_rd_addr;
  logic write_buf_update, read_buf_update, record_finish;
  bit_cnt_t replay_bits, record_bits;
  logic mem_wr_valid, mem_wr_ready, mem_rd_valid, mem_rd_ready, mem_rd_resp_valid;
  word_t mem_wr_data, mem_rd_resp_data;
  logic irq_req, irq_ack;
  irq_reason_t irq_reason;

  integer seed = 10348;
  integer rnd;
  int cyc = 0;
  int last_due = 0;
  int lat;
  bit rand_out = 0;
  word_t mem [256];
  word_t rd_q[$];
  int due_q[$];
  unit_t tbl_data [N_UNITS];
  unit_len_t tbl_len [N_UNITS];
  bit_cnt_t tbl_sum;
  word_addr_t wr_next;
  word_addr_t rd_next;

  tb_clkgen i_clkgen (.clk(clk), .rstn(rstn));

  rr_storage_backend i_rr_storage_backend (.*);

  tb_checker i_checker (
    .clk(clk), .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .in_len(in_len), .out_valid(out_valid), .out_ready(out_ready),
    .out_data(out_data), .out_len(out_len)
  );

  // Channels are packed LSB first right above the bitmap
  function automatic unit_t make_unit(input bitmap_t bm, input logic [127:0] v);
    unit_t u;
    int pos;
    u = unit_t'(bm);
    pos = `RR_CHANNEL_CNT;
    if (bm[0]) begin
      u = u | (unit_t'(v[7:0]) << pos);
      pos = pos + `RR_CH0_W;
    end
    if (bm[1]) begin
      u = u | (unit_t'(v[47:32]) << pos);
      pos = pos + `RR_CH1_W;
    end
    if (bm[2]) begin
      u = u | (unit_t'(v[87:64]) << pos);
      pos = pos + `RR_CH2_W;
    end
    if (bm[3]) u = u | (unit_t'(v[127:96]) << pos);
    return u;
  endfunction

  // The memory model takes writes and read requests mid-cycle
  always @(negedge clk) begin
    if (mem_wr_valid === 1'b1 && mem_wr_ready) begin
      // Words land back to back from the buffer base
      i_checker.check_value("mem_wr_addr", 128'(mem_wr_addr), 128'(wr_next));
      wr_next = wr_next + word_addr_t'(1);
      mem[mem_wr_addr[7:0]] = mem_wr_data;
    end
    if (mem_rd_valid === 1'b1 && mem_rd_ready) begin
      i_checker.check_value("mem_rd_addr", 128'(mem_rd_addr), 128'(rd_next));
      rd_next = rd_next + word_addr_t'(1);
      rd_q.push_back(mem[mem_rd_addr[7:0]]);
      lat = 1 + {$random(seed)} % 3;
      last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
      due_q.push_back(last_due);
    end
  end

  always @(posedge clk) begin
    #2;
    cyc++;
    rnd = $random(seed);
    mem_wr_ready = rnd[0];
    mem_rd_ready = rnd[1];
    out_ready = rand_out ? rnd[2] : 1'b1;
    mem_rd_resp_valid = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      mem_rd_resp_valid = 1'b1;
      mem_rd_resp_data = rd_q.pop_front();
      void'(due_q.pop_front());
    end
  end

  task automatic send_unit(input int i, input int limit, output bit ok);
    int n;
    ok = 0;
    n = 0;
    in_valid = 1'b1;
    in_data = tbl_data[i];
    in_len = tbl_len[i];
    while (!ok && n < limit) begin
      @(negedge clk);
      ok = in_ready;
      n++;
    end
    @(posedge clk);
    #2 in_valid = 1'b0;
  endtask

  task automatic wait_irq(input string what);
    int n;
    n = 0;
    while (irq_req !== 1'b1 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (irq_req !== 1'b1) i_checker.note_failure({"timeout waiting for ", what});
    @(posedge clk);
    #2;
  endtask

  task automatic ack_irq();
    irq_ack = 1'b1;
    @(posedge clk);
    #2 irq_ack = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic replay(input string name);
    int n;
    n = 0;
    i_checker.start_replay();
    replay_bits = tbl_sum;
    rd_next = buf_addr;
    read_buf_update = 1'b1;
    @(posedge clk);
    #2 read_buf_update = 1'b0;
    while ((i_checker.exp_left != 0 || irq_req !== 1'b1) && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (i_checker.exp_left != 0 || irq_req !== 1'b1) begin
      i_checker.note_failure("timeout waiting for the replay to finish");
    end
    rand_out = 0;
    i_checker.check_value("match_cnt", 128'(i_checker.match_cnt), 128'(N_UNITS));
    i_checker.check_value("irq_reason", 128'(irq_reason), 128'(3'b100));
    @(posedge clk);
    #2 ack_irq();
    i_checker.end_test(name);
  endtask

  initial begin
    #3000000;
    $display("Simulation time limit reached before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    bit ok;
    bit_cnt_t acc_bits;
    bitmap_t bm;
    int n;
    in_valid = 0;
    in_data = '0;
    in_len = '0;
    out_ready = 1;
    irq_ack = 0;
    buf_addr = 32'd16;
    buf_size = 32'd64;
    replay_bits = '0;
    write_buf_update = 0;
    read_buf_update = 0;
    record_finish = 0;
    mem_wr_ready = 0;
    mem_rd_ready = 0;
    mem_rd_resp_valid = 0;
    mem_rd_resp_data = '0;
    wr_next = '0;
    rd_next = '0;
    for (int a = 0; a < 256; a++) mem[a] = {~32'(a), 32'(a) * 32'h9e37_79b9};
    tbl_sum = '0;
    for (int i = 0; i < N_UNITS; i++) begin
      bm = bitmap_t'($random(seed));
      tbl_data[i] = make_unit(bm, {$random(seed), $random(seed), $random(seed),
                                   $random(seed)});
      tbl_len[i] = unit_len(bm);
      tbl_sum = tbl_sum + bit_cnt_t'(tbl_len[i]);
    end
    n = 0;
    while (rstn !== 1'b1 && n < TMO) begin
      @(posedge clk);
      n++;
    end
    if (rstn !== 1'b1) i_checker.note_failure("timeout waiting for the reset release");
    repeat (3) @(posedge clk);
    #2 write_buf_update = 1'b1;
    wr_next = buf_addr;
    i_checker.start_record();
    @(posedge clk);
    #2 write_buf_update = 1'b0;

    // Test 1 records the whole table and finishes
    for (int i = 0; i < N_UNITS; i++) begin
      send_unit(i, TMO, ok);
      if (!ok) i_checker.note_failure("timeout waiting for in_ready");
    end
    record_finish = 1'b1;
    @(posedge clk);
    #2 record_finish = 1'b0;
    wait_irq("the record interrupt");
    i_checker.check_value("irq_reason", 128'(irq_reason), 128'(3'b010));
    i_checker.check_value("record_bits", 128'(record_bits), 128'(tbl_sum));
    i_checker.end_test("record");

    // Test 2 keeps the request pending until the host acknowledges
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      i_checker.check_value("irq_req", 128'(irq_req), 128'(1));
    end
    @(posedge clk);
    #2 ack_irq();
    i_checker.check_value("irq_req", 128'(irq_req), 128'(0));
    i_checker.check_value("irq_reason", 128'(irq_reason), 128'(0));
    i_checker.end_test("irq_ack");

    replay("replay");
    rand_out = 1;
    replay("replay_stall");

    // Test 5 fills a two word buffer and must stall the input
    buf_addr = 32'd100;
    buf_size = 32'd2;
    wr_next = buf_addr;
    write_buf_update = 1'b1;
    @(posedge clk);
    #2 write_buf_update = 1'b0;
    acc_bits = '0;
    ok = 1;
    for (int i = 0; i < N_UNITS && ok; i++) begin
      send_unit(i, 40, ok);
      if (ok) acc_bits = acc_bits + bit_cnt_t'(tbl_len[i]);
    end
    if (ok) i_checker.note_failure("input was never stalled by the full buffer");
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      i_checker.check_value("in_ready", 128'(in_ready), 128'(0));
    end
    wait_irq("the buffer full interrupt");
    i_checker.check_value("irq_reason", 128'(irq_reason), 128'(3'b010));
    i_checker.check_value("record_bits", 128'(record_bits), 128'(128));
    if (acc_bits < 128) i_checker.note_failure("fewer bits accepted than written");
    ack_irq();
    i_checker.end_test("buffer_full");

    i_checker.summary();
    if (i_checker.err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/rr_pkg.sv
hdl/rr_stream_if.sv
hdl/rr_trace_packer.sv
hdl/rr_trace_writer.sv
hdl/rr_trace_reader.sv
hdl/rr_trace_unpacker.sv
hdl/rr_irq_ctrl.sv
hdl/rr_storage_backend.sv
tb/tb_clkgen.sv
tb/tb_checker.sv
tb/tb_storage_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_storage_backend
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
	  echo "Simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "All tests passed" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
